// ==== common/zero_fir_cfg.svh ====
`ifndef ZERO_FIR_CFG_SVH
`define ZERO_FIR_CFG_SVH

// samples carried by one vector, one vector per clock
`define ZF_NSAMP 8

// input samples are Q14.2
`define ZF_NBITS 16
`define ZF_NFRAC 2

// output samples, same Q14.2 format as the input
`define ZF_OUTBITS 16
`define ZF_OUTFRAC 2

// coefficients are Q4.14, so 1.0 is 16384
`define ZF_CBITS 18
`define ZF_CFRAC 14

// dat_i to dat_o in clocks
// one input register in the top plus three lane stages
`define ZF_LATENCY 4

`endif

// ==== common/zero_fir_pkg.sv ====
`include "zero_fir_cfg.svh"

package zero_fir_pkg;

   // derived widths of the datapath
   // pre-add of two samples grows by one bit
   localparam int PREADD_BITS = `ZF_NBITS + 1;
   // a * preadd is the wider of the two products
   localparam int PROD_BITS = PREADD_BITS + `ZF_CBITS;
   // sum of two products grows by one more bit
   localparam int ACC_BITS = PROD_BITS + 1;

   // one input sample
   typedef logic signed [`ZF_NBITS-1:0] sample_t;

   // one output sample
   typedef logic signed [`ZF_OUTBITS-1:0] out_sample_t;

   // Q4.14 coefficient
   typedef logic signed [`ZF_CBITS-1:0] coeff_t;

   // prev + next, one bit wider than a sample
   typedef logic signed [PREADD_BITS-1:0] preadd_t;

   // either product, sized for a * preadd
   typedef logic signed [PROD_BITS-1:0] prod_t;

   // a * preadd + b * sample without overflow
   typedef logic signed [ACC_BITS-1:0] acc_t;

   // lane 0 sits in the low bits
   typedef sample_t [`ZF_NSAMP-1:0] sample_vec_t;
   typedef out_sample_t [`ZF_NSAMP-1:0] out_vec_t;

   // unity in the coefficient format
   localparam coeff_t COEFF_ONE = coeff_t'(1 << `ZF_CFRAC);

endpackage

// ==== source/coeff_bank.sv ====
`timescale 1ns/1ps

module coeff_bank (
   input  logic                 clk,
   input  logic                 arst_n_i,
   input  zero_fir_pkg::coeff_t coeff_dat_i,
   input  logic                 coeff_wr_i,
   input  logic                 coeff_update_i,
   output zero_fir_pkg::coeff_t coeff_a_o,
   output zero_fir_pkg::coeff_t coeff_b_o
);
   import zero_fir_pkg::*;

   // two-deep shadow, older entry ends up as b
   coeff_t shadow_old_q;
   coeff_t shadow_new_q;

   // pair seen by the lanes
   coeff_t coeff_a_q;
   coeff_t coeff_b_q;

   // each write pushes the newer word down into the older slot
   // first write of a sequence is b, second is a
   always_ff @(posedge clk) begin
      if (coeff_wr_i) begin
         shadow_old_q <= shadow_new_q;
         shadow_new_q <= coeff_dat_i;
      end
   end

   // update copies both shadow words at once
   // reset value b = 1.0 and a = 0 makes the filter transparent
   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         coeff_a_q <= '0;
         coeff_b_q <= COEFF_ONE;
      end else if (coeff_update_i) begin
         coeff_b_q <= shadow_old_q;
         coeff_a_q <= shadow_new_q;
      end
   end

   assign coeff_a_o = coeff_a_q;
   assign coeff_b_o = coeff_b_q;

   // a write in the update cycle would make the active pair ambiguous
   // (shadow shifts while it is being copied)
   a_no_wr_with_update : assert property (
      @(posedge clk) disable iff (!arst_n_i)
      !(coeff_wr_i && coeff_update_i)
   ) else $error("coeff_bank: coefficient write and update in the same cycle");

endmodule

// ==== zero_fir/zero_fir_lane.sv ====
`timescale 1ns/1ps
`include "zero_fir_cfg.svh"

module zero_fir_lane (
   input  logic                      clk,
   input  logic                      arst_n_i,
   input  zero_fir_pkg::sample_t     prev_i,
   input  zero_fir_pkg::sample_t     this_i,
   input  zero_fir_pkg::sample_t     next_i,
   input  logic                      bypass_i,
   input  zero_fir_pkg::coeff_t      coeff_a_i,
   input  zero_fir_pkg::coeff_t      coeff_b_i,
   output zero_fir_pkg::out_sample_t dat_o
);
   import zero_fir_pkg::*;

   // bits dropped when going from the product format to the output format
   // products carry NFRAC + CFRAC fraction bits
   localparam int TRIM_SHIFT = `ZF_NFRAC + `ZF_CFRAC - `ZF_OUTFRAC;

   // stage 1, pre-add of the outer taps
   preadd_t s1_preadd_q;
   sample_t s1_this_q;
   logic    s1_bypass_q;

   // stage 2, products
   prod_t   s2_prod_a_q;
   prod_t   s2_prod_b_q;
   sample_t s2_this_q;
   logic    s2_bypass_q;

   // stage 3 input, either the filter sum or the sample scaled by 1.0
   acc_t    s3_acc;

   // stage 3, output register
   out_sample_t s3_dat_q;

   // band-stop numerator is symmetric
   // a*next + a*prev folds into a*(next + prev), one multiplier saved
   always_ff @(posedge clk) begin
      s1_preadd_q <= preadd_t'(prev_i) + preadd_t'(next_i);
      s1_this_q   <= this_i;
   end

   // both products in parallel
   // the centre sample rides along for the bypass path
   always_ff @(posedge clk) begin
      s2_prod_a_q <= s1_preadd_q * coeff_a_i;
      s2_prod_b_q <= s1_this_q * coeff_b_i;
      s2_this_q   <= s1_this_q;
   end

   // bypass flag follows its own sample through the pipe
   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         s1_bypass_q <= 1'b0;
         s2_bypass_q <= 1'b0;
      end else begin
         s1_bypass_q <= bypass_i;
         s2_bypass_q <= s1_bypass_q;
      end
   end

   // bypassed sample is lifted into the product format
   // so it goes through the same trim as the filtered value
   always_comb begin
      if (s2_bypass_q) begin
         s3_acc = acc_t'(s2_this_q) <<< `ZF_CFRAC;
      end else begin
         s3_acc = acc_t'(s2_prod_a_q) + acc_t'(s2_prod_b_q);
      end
   end

   // arithmetic shift floors toward minus infinity
   // the cast keeps the low OUTBITS bits, so overflow wraps
   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         s3_dat_q <= '0;
      end else begin
         s3_dat_q <= out_sample_t'(s3_acc >>> TRIM_SHIFT);
      end
   end

   assign dat_o = s3_dat_q;

   // an unknown bypass would turn the whole output vector to X three clocks later
   a_bypass_known : assert property (
      @(posedge clk) disable iff (!arst_n_i)
      !$isunknown(bypass_i)
   ) else $error("zero_fir_lane: bypass_i is unknown");

endmodule

// ==== zero_fir/zero_fir_top.sv ====
`timescale 1ns/1ps
`include "zero_fir_cfg.svh"

module zero_fir_top (
   input  logic                      clk,
   input  logic                      arst_n_i,
   input  zero_fir_pkg::sample_vec_t dat_i,
   input  logic                      bypass_i,
   input  zero_fir_pkg::coeff_t      coeff_dat_i,
   input  logic                      coeff_wr_i,
   input  logic                      coeff_update_i,
   output zero_fir_pkg::out_vec_t    dat_o
);
   import zero_fir_pkg::*;

   // vector currently being filtered
   sample_vec_t cur_q;
   logic        bypass_q;

   // last sample of the vector before cur_q
   sample_t     hist_q;

   // active coefficients, shared by every lane
   coeff_t      coeff_a;
   coeff_t      coeff_b;

   // input register, plus the one-sample history across vectors
   // all zero after reset, so the first vector sees zero neighbours
   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         cur_q    <= '0;
         bypass_q <= 1'b0;
         hist_q   <= '0;
      end else begin
         cur_q    <= dat_i;
         bypass_q <= bypass_i;
         hist_q   <= cur_q[`ZF_NSAMP-1];
      end
   end

   coeff_bank coeff_bank_inst (
      .clk            (clk),
      .arst_n_i       (arst_n_i),
      .coeff_dat_i    (coeff_dat_i),
      .coeff_wr_i     (coeff_wr_i),
      .coeff_update_i (coeff_update_i),
      .coeff_a_o      (coeff_a),
      .coeff_b_o      (coeff_b)
   );

   for (genvar i = 0; i < `ZF_NSAMP; i++) begin : g_lane
      sample_t lane_prev;
      sample_t lane_next;

      // lane 0 reaches back into the previous vector
      if (i == 0) begin : g_prev_hist
         assign lane_prev = hist_q;
      end else begin : g_prev_cur
         assign lane_prev = cur_q[i-1];
      end

      // last lane looks ahead at the vector arriving on dat_i right now
      // it is the one cur_q will hold next
      if (i == `ZF_NSAMP - 1) begin : g_next_live
         assign lane_next = dat_i[0];
      end else begin : g_next_cur
         assign lane_next = cur_q[i+1];
      end

      zero_fir_lane zero_fir_lane_inst (
         .clk       (clk),
         .arst_n_i  (arst_n_i),
         .prev_i    (lane_prev),
         .this_i    (cur_q[i]),
         .next_i    (lane_next),
         .bypass_i  (bypass_q),
         .coeff_a_i (coeff_a),
         .coeff_b_i (coeff_b),
         .dat_o     (dat_o[i])
      );
   end

endmodule

// ==== testbench/zero_fir_tb.sv ====
`timescale 1ns/1ps
`include "zero_fir_cfg.svh"

module zero_fir_tb;
   import zero_fir_pkg::*;

   // limits for the bounded loops
   localparam int MAX_LINES = 2000;
   localparam int MAX_CYCLES = 1000;
   localparam int RESET_WAIT_MAX = 50;
   localparam string VEC_FILE = "testbench/zero_fir_vectors.txt";

   logic        clk;
   logic        arst_n_i;
   sample_vec_t dat_i;
   logic        bypass_i;
   coeff_t      coeff_dat_i;
   logic        coeff_wr_i;
   logic        coeff_update_i;
   out_vec_t    dat_o;

   // fields of one vector line
   int f_chk;
   int f_byp;
   int f_wr;
   int f_upd;
   int f_cdat;
   int f_smp [`ZF_NSAMP];
   int f_exp [`ZF_NSAMP];

   int    fd;
   int    n_chars;
   int    n_fields;
   int    n_lines;
   int    n_cycles;
   int    n_checked;
   int    zero_run;
   int    wait_cnt;
   string line_str;

   zero_fir_top zero_fir_top_inst (
      .clk            (clk),
      .arst_n_i       (arst_n_i),
      .dat_i          (dat_i),
      .bypass_i       (bypass_i),
      .coeff_dat_i    (coeff_dat_i),
      .coeff_wr_i     (coeff_wr_i),
      .coeff_update_i (coeff_update_i),
      .dat_o          (dat_o)
   );

   // 10 ns clock
   initial begin
      clk = 1'b0;
      forever begin
         #5 clk = ~clk;
      end
   end

   // one lane of dat_o against the value from the vector file
   task automatic compare_sample(input int lane, input out_sample_t got,
                                 input out_sample_t exp);
      if (got !== exp) begin
         $display("MISMATCH time %0t lane %0d got %h expected %h", $time, lane, got, exp);
         $display("Regression failed");
         $fatal(1, "dat_o differs from the expected vector");
      end
   endtask

   // any failure that is not a data mismatch
   task automatic stop_on_error(input string what);
      $display("ERROR: %s", what);
      $display("Regression failed");
      $fatal(1, "run aborted");
   endtask

   // random data on dat_i while reset holds the input register at zero
   task automatic drive_idle_fill();
      for (int i = 0; i < `ZF_NSAMP; i++) begin
         dat_i[i] = sample_t'($urandom);
      end
   endtask

   initial begin
      void'($urandom(6));
      arst_n_i       = 1'b0;
      dat_i          = '0;
      bypass_i       = 1'b0;
      coeff_dat_i    = '0;
      coeff_wr_i     = 1'b0;
      coeff_update_i = 1'b0;
      n_lines        = 0;
      n_cycles       = 0;
      n_checked      = 0;

      // reset held for 10 clocks
      for (int c = 0; c < 9; c++) begin
         @(negedge clk);
         drive_idle_fill();
      end
      @(negedge clk);
      arst_n_i = 1'b1;
      dat_i    = '0;

      // zeros on dat_i flush the pipeline before the first vector
      zero_run = 0;
      wait_cnt = 0;
      while (zero_run < `ZF_LATENCY) begin
         @(negedge clk);
         if (dat_o == '0) begin
            zero_run++;
         end else begin
            zero_run = 0;
         end
         wait_cnt++;
         if (wait_cnt > RESET_WAIT_MAX) begin
            stop_on_error("dat_o did not settle to zero after reset");
         end
      end

      fd = $fopen(VEC_FILE, "r");
      if (fd == 0) begin
         stop_on_error("cannot open the vector file");
      end

      // each data line is one clock and is checked and driven on the falling edge
      while (!$feof(fd)) begin
         n_lines++;
         if (n_lines > MAX_LINES) begin
            stop_on_error("vector file reading did not finish");
         end
         n_chars = $fgets(line_str, fd);
         if (n_chars == 0 || line_str.len() == 0 || line_str.getc(0) == 8'h23) begin
            continue;
         end
         n_fields = $sscanf(line_str,
            "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
            f_chk, f_byp, f_wr, f_upd, f_cdat,
            f_smp[0], f_smp[1], f_smp[2], f_smp[3],
            f_smp[4], f_smp[5], f_smp[6], f_smp[7],
            f_exp[0], f_exp[1], f_exp[2], f_exp[3],
            f_exp[4], f_exp[5], f_exp[6], f_exp[7]);
         // blank line
         if (n_fields <= 0) begin
            continue;
         end
         if (n_fields != 21) begin
            stop_on_error("malformed line in the vector file");
         end

         @(negedge clk);
         n_cycles++;
         if (n_cycles > MAX_CYCLES) begin
            stop_on_error("vector run exceeded its cycle limit");
         end

         // expected values in the file are already shifted by the latency
         if (f_chk != 0) begin
            for (int i = 0; i < `ZF_NSAMP; i++) begin
               compare_sample(i, dat_o[i], out_sample_t'(f_exp[i]));
            end
            n_checked++;
         end

         bypass_i       = (f_byp != 0);
         coeff_wr_i     = (f_wr != 0);
         coeff_update_i = (f_upd != 0);
         coeff_dat_i    = coeff_t'(f_cdat);
         for (int i = 0; i < `ZF_NSAMP; i++) begin
            dat_i[i] = sample_t'(f_smp[i]);
         end
      end
      $fclose(fd);

      if (n_checked == 0) begin
         $display("ERROR: no output vector was checked");
         $display("Regression failed");
         $fatal(1, "empty vector run");
      end else begin
         $display("checked %0d output vectors", n_checked);
         $display("Regression passed");
         $finish;
      end
   end

endmodule

// ==== testbench/zero_fir_vectors.txt ====
# columns: check bypass coeff_wr coeff_update coeff_dat(18b) in0..in7 exp0..exp7, all hex
# exp is dat_o seen in the same cycle, lane 0 first
# default pair b=1.0 a=0, output is input four lines later
0 0 0 0 00000 0001 0002 0003 0004 0005 0006 0007 0008 0000 0000 0000 0000 0000 0000 0000 0000
0 0 0 0 00000 0009 000a 000b 000c 000d 000e 000f 0010 0000 0000 0000 0000 0000 0000 0000 0000
0 0 0 0 00000 ffff fffe fffd fffc fffb fffa fff9 fff8 0000 0000 0000 0000 0000 0000 0000 0000
0 0 0 0 00000 0100 0200 0300 0400 0500 0600 0700 0800 0000 0000 0000 0000 0000 0000 0000 0000
1 0 0 0 00000 7fff 8000 1234 edcb 0001 0000 ffff 4000 0001 0002 0003 0004 0005 0006 0007 0008
1 0 0 0 00000 0000 0000 0000 0000 0000 0000 0000 0000 0009 000a 000b 000c 000d 000e 000f 0010
# load b=-0.5 then a=0.25, update on the third line
1 0 1 0 3e000 0000 0000 0000 0000 0000 0000 0000 0000 ffff fffe fffd fffc fffb fffa fff9 fff8
1 0 1 0 01000 0000 0000 0000 0000 0000 0000 0000 0000 0100 0200 0300 0400 0500 0600 0700 0800
1 0 0 1 00000 0000 0000 0000 0000 0000 0000 0000 0000 7fff 8000 1234 edcb 0001 0000 ffff 4000
1 0 0 0 00000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
1 0 0 0 00000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
1 0 0 0 00000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
# three-tap filter y = floor((prev + next - 2*this) / 4)
1 0 0 0 00000 0004 0008 000c 0010 0014 0018 001c 0020 0000 0000 0000 0000 0000 0000 0000 0000
1 0 0 0 00000 0028 0000 ffd8 0000 0028 0000 ffd8 0000 0000 0000 0000 0000 0000 0000 0000 0000
1 0 0 0 00000 0064 0064 0064 0064 0064 0064 0064 0064 0000 0000 0000 0000 0000 0000 0000 0000
1 0 0 0 00000 0001 0000 0003 0000 0000 0005 0000 0002 0000 0000 0000 0000 0000 0000 0000 0001
1 0 0 0 00000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0001
1 0 0 0 00000 0000 0000 0000 0000 0000 0000 0000 0000 fff4 0000 0014 0000 ffec 0000 0014 000f
# shadow writes b=0.5 a=0.5 while the old pair stays active
1 0 1 0 02000 0002 0004 0006 0008 000a 000c 000e 0010 ffe7 0000 0000 0000 0000 0000 0000 ffe7
1 0 1 0 02000 fffd 0005 fff9 0009 fff5 000d fff1 0011 0018 0001 fffe 0000 0001 fffd 0001 ffff
1 0 0 0 00000 0008 0008 0008 0008 fff8 fff8 fff8 0000 0000 0000 0000 0000 0000 0000 0000 0000
1 0 0 0 00000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
1 0 0 0 00000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 fffa
1 0 0 1 00000 0000 0000 0000 0000 0000 0000 0000 0000 0006 fffb 0007 fff7 000b fff3 000f fff5
# new pair gives y = floor((prev + next + this) / 2)
1 0 0 0 00000 0000 0006 000c 0012 0018 001e 0024 002a 0002 0000 0000 fffc 0004 0000 0002 fffe
1 0 0 0 00000 0003 0001 0004 0001 0005 0009 0002 0006 0000 0000 0000 0000 0000 0000 0000 0000
1 0 0 0 00000 fff6 ffec ffe2 ffd8 ffce ffc4 ffba ffb0 0000 0000 0000 0000 0000 0000 0000 0000
1 0 0 0 00000 0001 0002 0003 0004 0005 0006 0007 0008 0000 0000 0000 0000 0000 0000 0000 0000
# two bypassed vectors between filtered ones
1 1 0 0 00000 000b 000d 0011 0013 0017 001d 001f 0025 0003 0009 0012 001b 0024 002d 0036 0028
1 1 0 0 00000 fffb fffb fffb fffb fffb fffb fffb fffb 0017 0004 0003 0005 0007 0008 0008 ffff
1 0 0 0 00000 000a 000a 000a 000a 000a 000a 000a 000a fff4 ffe2 ffd3 ffc4 ffb5 ffa6 ff97 ffb5
1 0 0 0 00000 0000 0000 0000 0000 0000 0000 0000 0000 ffd9 0003 0004 0006 0007 0009 000a 000d
1 0 0 0 00000 0000 0000 0000 0000 0000 0000 0000 0000 000b 000d 0011 0013 0017 001d 001f 0025
# large pair b=-8.0 a=3.75 for floor and wrap
1 0 1 0 20000 0000 0000 0000 0000 0000 0000 0000 0000 fffb fffb fffb fffb fffb fffb fffb fffb
1 0 1 0 0f000 0000 0000 0000 0000 0000 0000 0000 0000 0007 000f 000f 000f 000f 000f 000f 000a
1 0 0 0 00000 0000 0000 0000 0000 0000 0000 0000 0000 0005 0000 0000 0000 0000 0000 0000 0000
1 0 0 1 00000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
1 0 0 0 00000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
1 0 0 0 00000 1000 0001 0002 0003 fffd 7fff 8000 0005 0000 0000 0000 0000 0000 0000 0000 0000
1 0 0 0 00000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
1 0 0 0 00000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
1 0 0 0 00000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 3c00
1 0 0 0 00000 0000 0000 0000 0000 0000 0000 0000 0000 8003 3bff ffff ffe4 e01f 1ffc e00f 1fd8
1 0 0 0 00000 0000 0000 0000 0000 0000 0000 0000 0000 0012 0000 0000 0000 0000 0000 0000 0000
1 0 0 0 00000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000

// ==== files.f ====
+incdir+common
common/zero_fir_pkg.sv
source/coeff_bank.sv
zero_fir/zero_fir_lane.sv
zero_fir/zero_fir_top.sv
testbench/zero_fir_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the zero_fir testbench with Verilator and run it.
# Exit status is nonzero if the build fails or the simulation fails.

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
SIM_BIN=zero_fir_sim

command -v verilator >/dev/null 2>&1
if [ $? -ne 0 ]; then
   echo "verilator not found in PATH"
   exit 1
fi

verilator --binary --assert -Wno-fatal \
   -f files.f \
   --top-module zero_fir_tb \
   -Mdir "$OBJ_DIR" \
   -o "$SIM_BIN"
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit $status
fi

"./$OBJ_DIR/$SIM_BIN"
status=$?
if [ $status -ne 0 ]; then
   echo "simulation failed with status $status"
fi
exit $status
